// ==== program.hex ====
// One 32-bit instruction word per line, word address 0 first
20010005
2002FFFD
00221820
00222022
00222824
00223025
0041382A
00210020
AC820008
8C880008
FC290004
01284820
8C8A0008
10220005
10E70001
20010063
1022FFFC
200B0040
200C0060
AD6B0000
8D6D0000
216B0004
116C0001
1000FFFB
1000FFFF

// ==== compile.f ====
mips_pkg.sv
fetch_unit.sv
instr_mem.sv
control_unit.sv
reg_file.sv
alu.sv
data_mem.sv
mips.sv
tb_clk_gen.sv
mips_chk.sv
mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips

sources:
  - mips_pkg.sv
  - fetch_unit.sv
  - instr_mem.sv
  - control_unit.sv
  - reg_file.sv
  - alu.sv
  - data_mem.sv
  - mips.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - mips_chk.sv
      - mips_tb.sv

// ==== mips_tb.sv ====
`default_nettype none

module mips_tb import mips_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int period_ns      = 40;
	localparam int reset_cycles   = 16;
	localparam int timeout_cycles = 200;  // Limit for reaching the final self branch
	localparam int sample_delay   = period_ns / 2 - 1;  // 1 ns before the rising edge

	logic            clock;
	logic            arst_n;
	logic [xlen-1:0] next_pc;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] mem_rdata;

	logic [xlen-1:0] prog [imem_depth];    // Own copy of the image
	logic [xlen-1:0] m_regs [32];          // Model register file
	logic [xlen-1:0] m_mem [dmem_depth];   // Model data RAM left unknown until stored
	logic [xlen-1:0] m_pc;
	logic [xlen-1:0] end_pc;               // Address of beq $0,$0,-1
	int              errors [1:6];         // Per behavior
	int              hits [1:6];
	int              checks;
	int              total_errors;
	int              cycles;
	bit              timed_out;
	bit              done;

	tb_clk_gen #(.period_ns(period_ns)) u_clk (.clock(clock));

	mips u_mips (
		.clock(clock), .arst_n(arst_n), .next_pc(next_pc),
		.alu_result(alu_result), .mem_rdata(mem_rdata)
	);

	// Instruction word at a byte address and zero past the ROM
	function automatic logic [xlen-1:0] fetch_word(input logic [xlen-1:0] addr);
		if ((addr >> 2) >= imem_depth) begin
			return '0;
		end
		return prog[addr[7:2]];
	endfunction

	// Behavior a cycle belongs to, by opcode
	function automatic int kind_of(input logic [xlen-1:0] ins);
		case (ins[31:26])
			op_rtype:       return 2;
			op_addi:        return 3;
			op_lw, op_sw:   return 4;
			op_beq:         return 5;
			default:        return 6;  // Outside the subset
		endcase
	endfunction

	// Expected outputs for the instruction at pc from the model state
	function automatic void predict(input logic [xlen-1:0] pc,
		output logic [xlen-1:0] exp_next, output logic [xlen-1:0] exp_alu,
		output logic [xlen-1:0] exp_rdata, output bit alu_known);
		logic [xlen-1:0] ins;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm;
		ins       = fetch_word(pc);
		a         = m_regs[ins[25:21]];  // rs
		b         = m_regs[ins[20:16]];  // rt
		imm       = {{16{ins[15]}}, ins[15:0]};
		exp_next  = pc + 32'd4;
		exp_rdata = '0;  // Quiet unless lw
		exp_alu   = '0;
		alu_known = 1'b1;
		case (ins[31:26])
			op_rtype: begin
				case (ins[5:0])
					fn_add: exp_alu = a + b;
					fn_sub: exp_alu = a - b;
					fn_and: exp_alu = a & b;
					fn_or:  exp_alu = a | b;
					fn_slt: exp_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: alu_known = 1'b0;  // No result defined for a nop
				endcase
			end
			op_addi, op_sw: exp_alu = a + imm;
			op_lw: begin
				exp_alu   = a + imm;
				exp_rdata = m_mem[exp_alu[7:2]];  // Word index from bits 7 to 2
			end
			op_beq: begin
				exp_alu = a - b;
				if (a == b) begin
					exp_next = pc + 32'd4 + (imm << 2);
				end
			end
			default: alu_known = 1'b0;  // Outside the subset
		endcase
	endfunction

	// Apply the register or memory write of the current instruction
	task automatic commit(input logic [xlen-1:0] exp_next, input logic [xlen-1:0] exp_alu,
		input logic [xlen-1:0] exp_rdata, input bit alu_known);
		logic [xlen-1:0] ins;
		ins = fetch_word(m_pc);
		case (ins[31:26])
			op_rtype: begin
				if (alu_known && ins[15:11] != 5'd0) begin
					m_regs[ins[15:11]] = exp_alu;
				end
			end
			op_addi: if (ins[20:16] != 5'd0) m_regs[ins[20:16]] = exp_alu;
			op_lw:   if (ins[20:16] != 5'd0) m_regs[ins[20:16]] = exp_rdata;
			op_sw:   m_mem[exp_alu[7:2]] = m_regs[ins[20:16]];
			default: ;  // No state change
		endcase
		m_pc = exp_next;
	endtask

	task automatic check_word(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual, input int kind);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h at pc %h",
				name, expected, actual, m_pc);
			errors[kind]++;
		end
	endtask

	task automatic report(input int kind, input string title);
		if (hits[kind] == 0) begin
			$display("%s: the program never ran this kind of instruction", title);
			errors[kind]++;
		end else if (errors[kind] == 0) begin
			$display("%s: passed over %0d cycles", title, hits[kind]);
		end else begin
			$display("%s: failed with %0d errors", title, errors[kind]);
		end
	endtask

	initial begin
		logic [xlen-1:0] exp_next;
		logic [xlen-1:0] exp_alu;
		logic [xlen-1:0] exp_rdata;
		bit              alu_known;
		int              kind;
		arst_n    = 1'b0;
		checks    = 0;
		cycles    = 0;
		timed_out = 1'b0;
		done      = 1'b0;
		end_pc    = '1;  // Unreachable unless the image has the self branch
		for (int i = 1; i <= 6; i++) begin
			errors[i] = 0;
			hits[i]   = 0;
		end
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < imem_depth; i++) begin
			prog[i] = '0;
		end
		$readmemh(imem_file, prog);
		// Locate beq $0,$0,-1
		for (int i = imem_depth - 1; i >= 0; i--) begin
			if (prog[i] == {op_beq, 10'd0, 16'hffff}) end_pc = i * 4;
		end
		if (end_pc == '1) begin
			$display("The program image holds no final self branch");
		end

		repeat (reset_cycles) @(negedge clock);
		arst_n = 1'b1;  // Released on a falling edge
		m_pc   = '0;

		// Per-cycle compare until the self branch is reached
		while (!done && !timed_out) begin
			#(sample_delay);
			predict(m_pc, exp_next, exp_alu, exp_rdata, alu_known);
			kind = kind_of(fetch_word(m_pc));
			hits[kind]++;
			if (cycles == 0) begin
				hits[1] = 1;
				check_word("pc", 32'd0, u_mips.pc, 1);
				check_word("next_pc", exp_next, next_pc, 1);
				report(1, "Reset and first fetch");
			end
			check_word("next_pc", exp_next, next_pc, kind);
			if (alu_known) begin
				check_word("alu_result", exp_alu, alu_result, kind);
			end
			check_word("mem_rdata", exp_rdata, mem_rdata, kind);
			if (next_pc == end_pc && m_pc == end_pc) done = 1'b1;
			commit(exp_next, exp_alu, exp_rdata, alu_known);
			cycles++;
			if (!done && cycles >= timeout_cycles) timed_out = 1'b1;
			@(negedge clock);
		end

		if (timed_out) begin
			$display("Timeout: the final branch at %h was not reached within %0d cycles",
				end_pc, timeout_cycles);
		end
		report(2, "R-type add sub and or slt");
		report(3, "addi with sign-extended immediates");
		report(4, "sw and lw through the data RAM");
		report(5, "beq taken and not taken");
		report(6, "Unknown opcode as no-operation");

		total_errors = (end_pc == '1) ? 1 : 0;
		for (int i = 1; i <= 6; i++) begin
			total_errors += errors[i];
		end
		$display("Summary: %0d checks, %0d errors, %0d cycles", checks, total_errors, cycles);
		if (timed_out || total_errors != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips_chk.sv ====
`default_nettype none

module mips_chk import mips_pkg::*; (
	input wire            clock,
	input wire            arst_n,
	input wire [xlen-1:0] pc,
	input wire [xlen-1:0] next_pc,
	input wire [xlen-1:0] imm_ext,       // Branch offset in words
	input wire            branch_taken,
	input wire            mem_read,
	input wire            mem_write
);

	timeunit 1ns;
	timeprecision 100ps;

	// Instruction fetch is always whole words
	a_next_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n)
		next_pc[1:0] == 2'b00)
		else $error("next_pc %h is not word aligned", next_pc);

	// First edge out of reset sees the cleared PC
	a_pc_after_reset: assert property (@(posedge clock) $rose(arst_n) |-> pc == '0)
		else $error("pc %h after reset release", pc);

	a_mem_rw_exclusive: assert property (@(posedge clock) disable iff (!arst_n)
		!(mem_read && mem_write))
		else $error("Load and store decoded together");

	// A jump away from the successor needs a real offset
	a_branch_offset: assert property (@(posedge clock) disable iff (!arst_n)
		(branch_taken && next_pc != pc + xlen'(4)) |-> imm_ext != '0)
		else $error("Taken branch moved with a zero offset");

endmodule

bind mips mips_chk u_chk (
	.clock(clock), .arst_n(arst_n), .pc(pc), .next_pc(next_pc),
	.imm_ext(imm_ext), .branch_taken(branch_taken),
	.mem_read(mem_read), .mem_write(mem_write)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
	parameter int period_ns = 40  // Full clock period
) (
	output logic clock
);

	timeunit 1ns;
	timeprecision 100ps;

	// Starts low so the first edge is a rising one
	initial begin
		clock = 1'b0;
	end

	always #(period_ns / 2) clock = ~clock;  // Free running

endmodule

`default_nettype wire

// ==== mips.sv ====
`default_nettype none

module mips import mips_pkg::*; (
	input  wire             clock,
	input  wire             arst_n,
	output logic [xlen-1:0] next_pc,     // PC for the following cycle
	output logic [xlen-1:0] alu_result,
	output logic [xlen-1:0] mem_rdata    // Zero unless lw
);

	logic [xlen-1:0]   pc;
	logic [xlen-1:0]   instr;
	logic              reg_dst;
	logic              alu_src;
	logic              mem_to_reg;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic              branch;
	alu_op_t           alu_op;
	logic [reg_aw-1:0] write_reg;
	logic [xlen-1:0]   rdata1;
	logic [xlen-1:0]   rdata2;
	logic [xlen-1:0]   imm_ext;     // Sign-extended instr[15:0]
	logic [xlen-1:0]   alu_b;
	logic [xlen-1:0]   write_data;  // Write-back value
	logic              zero;
	logic              branch_taken;

	fetch_unit u_fetch (
		.clock(clock), .arst_n(arst_n), .imm_ext(imm_ext),
		.branch_taken(branch_taken), .pc(pc), .next_pc(next_pc)
	);

	instr_mem u_imem (.addr(pc), .instr(instr));

	control_unit u_ctrl (
		.opcode(instr[31:26]), .funct(instr[5:0]),
		.reg_dst(reg_dst), .alu_src(alu_src), .mem_to_reg(mem_to_reg),
		.reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
		.branch(branch), .alu_op(alu_op)
	);

	// rd for R-type and rt for addi or lw
	assign write_reg = reg_dst ? instr[15:11] : instr[20:16];

	reg_file u_regs (
		.clock(clock), .arst_n(arst_n),
		.raddr1(instr[25:21]), .raddr2(instr[20:16]),
		.rdata1(rdata1), .rdata2(rdata2),
		.waddr(write_reg), .wdata(write_data), .wen(reg_write)
	);

	assign imm_ext = {{(xlen-16){instr[15]}}, instr[15:0]};
	assign alu_b   = alu_src ? imm_ext : rdata2;  // Operand b select

	alu u_alu (.a(rdata1), .b(alu_b), .op(alu_op), .result(alu_result), .zero(zero));

	// beq goes only on equal operands
	assign branch_taken = branch & zero;

	data_mem u_dmem (
		.clock(clock), .arst_n(arst_n), .addr(alu_result), .wdata(rdata2),
		.rdata(mem_rdata), .wen(mem_write), .ren(mem_read)
	);

	assign write_data = mem_to_reg ? mem_rdata : alu_result;  // Load or ALU

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`default_nettype none

module data_mem import mips_pkg::*; (
	input  wire             clock,
	input  wire             arst_n,
	input  wire  [xlen-1:0] addr,   // Byte address from the ALU
	input  wire  [xlen-1:0] wdata,  // rt for sw
	output logic [xlen-1:0] rdata,
	input  wire             wen,    // sw
	input  wire             ren     // lw
);

	logic [xlen-1:0]    ram [dmem_depth];  // Not cleared by reset
	logic [dmem_aw-1:0] word_idx;
	logic               wr_en;

	assign word_idx = addr[dmem_aw+1:2];  // Whole words only

	// No store while the core is held in reset
	assign wr_en = wen & arst_n;

	always_ff @(posedge clock) begin
		if (wr_en) begin
			ram[word_idx] <= wdata;
		end
	end

	// Quiet bus unless a load is in flight
	assign rdata = ren ? ram[word_idx] : '0;

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu import mips_pkg::*; (
	input  wire  [xlen-1:0] a,       // rs
	input  wire  [xlen-1:0] b,       // rt or immediate
	input  wire  alu_op_t   op,
	output logic [xlen-1:0] result,
	output logic            zero     // Drives the beq decision
);

	logic [xlen-1:0] sum;   // a plus b
	logic [xlen-1:0] diff;  // a minus b
	logic            lt;    // Signed a below b

	// Wrap around with no overflow trap
	assign sum  = a + b;
	assign diff = a - b;

	// Signed compare
	assign lt = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			alu_add: result = sum;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {{(xlen-1){1'b0}}, lt};  // One or zero
			default: result = '0;
		endcase
	end

	// High for any all-zero result
	// beq relies on it after sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file import mips_pkg::*; (
	input  wire               clock,
	input  wire               arst_n,
	input  wire  [reg_aw-1:0] raddr1,  // rs
	input  wire  [reg_aw-1:0] raddr2,  // rt
	output logic [xlen-1:0]   rdata1,
	output logic [xlen-1:0]   rdata2,
	input  wire  [reg_aw-1:0] waddr,   // rd or rt
	input  wire  [xlen-1:0]   wdata,
	input  wire               wen
);

	logic [xlen-1:0] regs [nregs];

	// Write port
	// Reset has priority so nothing lands while arst_n is low
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < nregs; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;  // $zero never written
		end
	end

	// Read ports
	// Combinational so a same-cycle write shows only after the edge
	always_comb begin
		rdata1 = regs[raddr1];
		rdata2 = regs[raddr2];
		// Hard zero for $zero as well
		if (raddr1 == '0) begin
			rdata1 = '0;
		end
		if (raddr2 == '0) begin
			rdata2 = '0;
		end
	end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`default_nettype none

module control_unit import mips_pkg::*; (
	input  wire  [5:0] opcode,      // instr[31:26]
	input  wire  [5:0] funct,       // instr[5:0]
	output logic       reg_dst,     // Write rd instead of rt
	output logic       alu_src,     // Immediate as operand b
	output logic       mem_to_reg,  // Load data to the register file
	output logic       reg_write,
	output logic       mem_read,
	output logic       mem_write,
	output logic       branch,
	output alu_op_t    alu_op
);

	// Coarse ALU request from the main decoder
	typedef enum logic [1:0] {
		ctl_add,    // Address or immediate sum
		ctl_sub,    // Equality compare
		ctl_funct   // Look at the function field
	} alu_ctl_t;

	alu_ctl_t alu_ctl;
	logic     main_reg_write;  // Before the funct check
	logic     funct_ok;        // Function field is in the subset

	// Main decoder
	always_comb begin
		reg_dst        = 1'b0;
		alu_src        = 1'b0;
		mem_to_reg     = 1'b0;
		main_reg_write = 1'b0;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		branch         = 1'b0;
		alu_ctl        = ctl_add;
		case (opcode)
			op_rtype: begin
				reg_dst        = 1'b1;
				main_reg_write = 1'b1;
				alu_ctl        = ctl_funct;
			end
			op_addi: begin
				alu_src        = 1'b1;
				main_reg_write = 1'b1;
			end
			op_lw: begin
				alu_src        = 1'b1;  // base plus offset
				mem_to_reg     = 1'b1;
				main_reg_write = 1'b1;
				mem_read       = 1'b1;
			end
			op_sw: begin
				alu_src   = 1'b1;
				mem_write = 1'b1;  // rt goes out as store data
			end
			op_beq: begin
				branch  = 1'b1;
				alu_ctl = ctl_sub;  // zero flag means equal
			end
			default: ;  // Unknown opcode is a nop
		endcase
	end

	// ALU decoder
	always_comb begin
		funct_ok = 1'b1;
		alu_op   = alu_add;
		case (alu_ctl)
			ctl_add: alu_op = alu_add;
			ctl_sub: alu_op = alu_sub;
			default: begin
				case (funct)
					fn_add:  alu_op = alu_add;
					fn_sub:  alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_slt:  alu_op = alu_slt;
					default: funct_ok = 1'b0;  // Includes sll and friends
				endcase
			end
		endcase
	end

	// Unsupported R-type must not touch the register file
	assign reg_write = main_reg_write & funct_ok;

endmodule

`default_nettype wire

// ==== instr_mem.sv ====
`default_nettype none

module instr_mem import mips_pkg::*; (
	input  wire  [xlen-1:0] addr,   // Byte address from the PC
	output logic [xlen-1:0] instr
);

	logic [xlen-1:0]    rom [imem_depth];  // Program words
	logic [imem_aw-1:0] word_idx;
	logic               in_range;

	// Clear first so words missing from the image read as a nop
	initial begin
		for (int i = 0; i < imem_depth; i++) begin
			rom[i] = '0;
		end
		$readmemh(imem_file, rom);
	end

	assign word_idx = addr[imem_aw+1:2];  // Byte offset bits dropped

	// Upper address bits must be clear to hit the ROM
	assign in_range = (addr[xlen-1:imem_aw+2] == '0);

	// Zero word past the end decodes as R-type funct 0
	assign instr = in_range ? rom[word_idx] : '0;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit import mips_pkg::*; (
	input  wire              clock,
	input  wire              arst_n,
	input  wire  [xlen-1:0]  imm_ext,       // Sign-extended branch offset in words
	input  wire              branch_taken,  // beq with equal operands
	output logic [xlen-1:0]  pc,            // Address of the instruction in flight
	output logic [xlen-1:0]  next_pc
);

	logic [xlen-1:0] pc_plus4;       // Sequential successor
	logic [xlen-1:0] branch_offset;  // Offset in bytes
	logic [xlen-1:0] branch_target;

	// Program counter
	// Loads next_pc on every edge since nothing stalls
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;  // Fetch starts at word zero
		end else begin
			pc <= next_pc;
		end
	end

	assign pc_plus4 = pc + xlen'(4);

	// Word offset to byte offset
	assign branch_offset = {imm_ext[xlen-3:0], 2'b00};

	// Relative to the delay-free successor as on MIPS
	assign branch_target = pc_plus4 + branch_offset;

	// Next PC select
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;  // Also covers every nop
		end
	end

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// Datapath width
	localparam int xlen = 32;

	// Register file geometry
	localparam int reg_aw = 5;            // rs rt and rd field width
	localparam int nregs  = 1 << reg_aw;  // 32 architectural registers

	// Instruction ROM
	localparam int    imem_depth = 64;                  // Words
	localparam int    imem_aw    = $clog2(imem_depth);  // Word index width
	localparam string imem_file  = "program.hex";       // Image read at elaboration

	// Data RAM
	localparam int dmem_depth = 64;                  // Words
	localparam int dmem_aw    = $clog2(dmem_depth);  // Word index width

	// Primary opcodes in instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;  // Register-register ops
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// R-type function field values in instr[5:0]
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	// ALU operation select
	// Classic MIPS textbook coding
	typedef enum logic [3:0] {
		alu_and = 4'b0000,
		alu_or  = 4'b0001,
		alu_add = 4'b0010,
		alu_sub = 4'b0110,  // Also used by beq for the equality test
		alu_slt = 4'b0111   // Signed set on less than
	} alu_op_t;

endpackage

`default_nettype wire
